// ==== rtl/core_ctrl_pkg.sv ====
// Issue controller shared types
`default_nettype none

package core_ctrl_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and address width
  localparam int unsigned XLEN = 32;
  // Register index width
  localparam int unsigned RALEN = 5;
  // Store flag inside a load/store command
  localparam int unsigned LSU_STORE_BIT = 3;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  // Addresses and ALU results
  typedef logic [XLEN-1:0] word_t;
  // Register index, zero is the hard-wired zero register
  typedef logic [RALEN-1:0] reg_addr_t;
  // Bit 3 marks a store, bits 1..0 give the access size
  typedef logic [3:0] lsu_cmd_t;

  // What decode knows about the instruction waiting to issue
  typedef struct packed {
    reg_addr_t rs_a;
    reg_addr_t rs_b;
    logic      use_pc_a;   // Operand A comes from the PC
    logic      use_imm_b;  // Operand B comes from the immediate
    lsu_cmd_t  lsu_cmd;
    logic      lsu_valid;  // Memory access
  } decode_fields_t;

  // Fetch redirect request
  typedef struct packed {
    logic  valid;
    word_t addr;
  } redirect_t;

endpackage

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
// Read-after-write hazard detection
`default_nettype none

module hazard_unit import core_ctrl_pkg::*; (
  input  decode_fields_t fields_i,
  input  reg_addr_t      alu_rd_i,
  output logic           hazard_o
);

  ////////////////////////////////////////
  // Operand usage
  ////////////////////////////////////////

  logic is_store;
  logic reads_a;
  logic reads_b;
  logic match_a;
  logic match_b;

  // Store data rides on the B read port
  assign is_store = fields_i.lsu_valid && fields_i.lsu_cmd[LSU_STORE_BIT];

  // Operand A is a register unless the PC is selected
  assign reads_a = !fields_i.use_pc_a;
  // Operand B is read for register ops and for any store
  assign reads_b = !fields_i.use_imm_b || is_store;

  ////////////////////////////////////////
  // Compare with ALU destination
  ////////////////////////////////////////

  // The zero register never carries a dependency
  assign match_a = (fields_i.rs_a == alu_rd_i) &&
                   (fields_i.rs_a != reg_addr_t'(0));
  assign match_b = (fields_i.rs_b == alu_rd_i) &&
                   (fields_i.rs_b != reg_addr_t'(0));

  // Any real source hitting the in-flight result
  assign hazard_o = (reads_a && match_a) || (reads_b && match_b);

endmodule

`default_nettype wire

// ==== rtl/issue_fsm.sv ====
// Issue sequencing state machine
`default_nettype none

module issue_fsm import core_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rstn_i,
  input  logic     hazard_i,
  input  lsu_cmd_t lsu_cmd_i,
  input  logic     lsu_valid_i,
  input  logic     lsu_ready_i,
  input  logic     jump_i,
  output logic     stall_o,
  output logic     flush_o,
  output logic     boot_redirect_o,
  output logic     jump_redirect_o
);

  typedef enum logic [2:0] {
    RESET,
    BOOT0,
    BOOT1,
    RUN,
    LOAD0,
    LOAD1,
    JUMP0,
    JUMP1
  } issue_state_e;

  issue_state_e state_q;
  issue_state_e state_next;

  logic load_req;
  logic jump_req;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  // Loads only, stores complete without waiting
  assign load_req = lsu_valid_i && !lsu_cmd_i[LSU_STORE_BIT];
  assign jump_req = jump_i;

  always_comb begin
    state_next = state_q;
    case (state_q)
      RESET: state_next = BOOT0;
      BOOT0: state_next = BOOT1;
      BOOT1: state_next = RUN;
      RUN: begin
        // Jump wins over a load in the same cycle
        if (jump_req) begin
          state_next = JUMP0;
        end else if (load_req) begin
          state_next = LOAD0;
        end
      end
      LOAD0: state_next = LOAD1;
      // Variable latency, wait for the LSU
      LOAD1: begin
        if (lsu_ready_i) begin
          state_next = RUN;
        end
      end
      JUMP0: state_next = JUMP1;
      JUMP1: state_next = RUN;
      default: state_next = RESET;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= RESET;
    end else begin
      state_q <= state_next;
    end
  end

  ////////////////////////////////////////
  // Output decode
  ////////////////////////////////////////

  // Hazard stalls combinationally, load and jump stall by state
  assign stall_o = hazard_i ||
                   (state_q == LOAD0) || (state_q == LOAD1) ||
                   (state_q == JUMP0) || (state_q == JUMP1);

  // Younger instructions are dropped as soon as the jump resolves
  assign flush_o = jump_i;

  // One-cycle redirect strobes
  assign boot_redirect_o = (state_q == BOOT0) && (state_next == BOOT1);
  assign jump_redirect_o = (state_q == JUMP0) && (state_next == JUMP1);

endmodule

`default_nettype wire

// ==== rtl/pc_counter.sv ====
// Program counter and fetch redirect
`default_nettype none

module pc_counter import core_ctrl_pkg::*; #(
  parameter word_t BOOT_ADDR = 32'h8000_0000
) (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      boot_redirect_i,
  input  logic      jump_redirect_i,
  input  logic      issued_i,
  input  word_t     alu_res_i,
  output word_t     pc_o,
  output redirect_t redirect_o
);

  word_t pc_q;
  word_t jump_addr;
  word_t target;

  ////////////////////////////////////////
  // Redirect target
  ////////////////////////////////////////

  // Bit 0 of a jump target is always dropped
  assign jump_addr = {alu_res_i[XLEN-1:1], 1'b0};

  assign target = jump_redirect_i ? jump_addr : BOOT_ADDR;

  assign redirect_o.valid = boot_redirect_i || jump_redirect_i;
  assign redirect_o.addr  = target;

  ////////////////////////////////////////
  // PC register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      pc_q <= BOOT_ADDR;
    end else if (redirect_o.valid) begin
      // Redirect overrides a same-cycle issue
      pc_q <= target;
    end else if (issued_i) begin
      pc_q <= pc_q + word_t'(4);
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== rtl/core_ctrl_top.sv ====
// Issue controller top level
`default_nettype none

module core_ctrl_top import core_ctrl_pkg::*; #(
  parameter word_t BOOT_ADDR = 32'h8000_0000
) (
  input  logic           clk_i,
  input  logic           rstn_i,
  input  decode_fields_t fields_i,
  input  reg_addr_t      alu_rd_i,
  input  word_t          alu_res_i,
  input  logic           jump_i,
  input  logic           instr_issued_i,
  input  logic           lsu_ready_i,
  output logic           stall_o,
  output logic           flush_o,
  output word_t          pc_o,
  output redirect_t      redirect_o
);

  logic hazard_stall;
  logic boot_redirect;
  logic jump_redirect;

  ////////////////////////////////////////
  // Operand hazard check
  ////////////////////////////////////////

  hazard_unit i_hazard_unit (
    .fields_i (fields_i),
    .alu_rd_i (alu_rd_i),
    .hazard_o (hazard_stall)
  );

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  issue_fsm i_issue_fsm (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .hazard_i        (hazard_stall),
    .lsu_cmd_i       (fields_i.lsu_cmd),
    .lsu_valid_i     (fields_i.lsu_valid),
    .lsu_ready_i     (lsu_ready_i),
    .jump_i          (jump_i),
    .stall_o         (stall_o),
    .flush_o         (flush_o),
    .boot_redirect_o (boot_redirect),
    .jump_redirect_o (jump_redirect)
  );

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////

  pc_counter #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_pc_counter (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .boot_redirect_i (boot_redirect),
    .jump_redirect_i (jump_redirect),
    .issued_i        (instr_issued_i),
    .alu_res_i       (alu_res_i),
    .pc_o            (pc_o),
    .redirect_o      (redirect_o)
  );

endmodule

`default_nettype wire

// ==== tests/core_ctrl_properties.sv ====
// Redirect and flush assertions
`default_nettype none

module core_ctrl_properties import core_ctrl_pkg::*; (
  input logic      clk_i,
  input logic      rstn_i,
  input logic      jump_i,
  input logic      flush_i,
  input redirect_t redirect_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions
  int assert_fails = 0;

  // Redirect is a one-cycle strobe, boot and jump alike
  redirect_single: assert property (
    @(posedge clk_i) disable iff (!rstn_i) redirect_i.valid |=> !redirect_i.valid
  ) else begin
    assert_fails++;
    $error("redirect valid high on two consecutive cycles");
  end

  // Flush only follows a resolved jump
  flush_on_jump: assert property (
    @(posedge clk_i) disable iff (!rstn_i) flush_i |-> jump_i
  ) else begin
    assert_fails++;
    $error("flush high without jump");
  end

  // Fetch targets stay halfword aligned
  redirect_aligned: assert property (
    @(posedge clk_i) disable iff (!rstn_i) !redirect_i.addr[0]
  ) else begin
    assert_fails++;
    $error("redirect address has bit 0 set");
  end

endmodule

bind core_ctrl_top core_ctrl_properties i_properties (
  .clk_i      (clk_i),
  .rstn_i     (rstn_i),
  .jump_i     (jump_i),
  .flush_i    (flush_o),
  .redirect_i (redirect_o)
);

`default_nettype wire

// ==== tests/core_ctrl_checker.sv ====
// Output comparison against vectors
`default_nettype none

module core_ctrl_checker import core_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       active_i,
  input  logic       done_i,
  input  logic [7:0] test_i,
  input  logic [4:0] mask_i,
  input  logic       exp_stall_i,
  input  logic       exp_flush_i,
  input  redirect_t  exp_redirect_i,
  input  word_t      exp_pc_i,
  input  logic       stall_i,
  input  logic       flush_i,
  input  redirect_t  redirect_i,
  input  word_t      pc_i,
  output int         pass_count_o,
  output int         error_count_o,
  output logic       report_done_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int         passes      = 0;
  int         errors      = 0;
  int         test_checks = 0;
  int         test_errors = 0;
  logic [7:0] cur_test    = '0;
  logic       closed      = 1'b0;

  // One compared field
  task automatic compare_field(input string name, input word_t got, input word_t exp);
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("** Error at %0d ns: test %0d %s is %h, expected %h",
               $time, cur_test, name, got, exp);
    end else begin
      passes++;
    end
  endtask

  // Line for the test that just ended
  task automatic close_test();
    if (test_checks > 0) begin
      $display("Finished test %0d: %0d checks, %0d errors",
               cur_test, test_checks, test_errors);
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  ////////////////////////////////////////
  // Sample on the rising edge
  ////////////////////////////////////////

  // Inputs change on the falling edge, so all values are settled here
  always @(posedge clk_i) begin
    if (active_i) begin
      if (test_i != cur_test) begin
        close_test();
        cur_test = test_i;
      end
      if (mask_i[0]) compare_field("stall_o", word_t'(stall_i), word_t'(exp_stall_i));
      if (mask_i[1]) compare_field("flush_o", word_t'(flush_i), word_t'(exp_flush_i));
      if (mask_i[2]) begin
        compare_field("redirect_o.valid", word_t'(redirect_i.valid),
                      word_t'(exp_redirect_i.valid));
      end
      if (mask_i[3]) compare_field("redirect_o.addr", redirect_i.addr, exp_redirect_i.addr);
      if (mask_i[4]) compare_field("pc_o", pc_i, exp_pc_i);
    end else if (done_i && !closed) begin
      close_test();
      closed = 1'b1;
    end
  end

  assign pass_count_o  = passes;
  assign error_count_o = errors;
  assign report_done_o = closed;

endmodule

`default_nettype wire

// ==== tests/core_ctrl_tb.sv ====
// Issue controller testbench
`default_nettype none

module core_ctrl_tb import core_ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_PERIOD   = 100;
  localparam int    RESET_CYCLES = 5;
  localparam word_t BOOT_ADDR    = 32'h8000_0000;
  localparam string VEC_FILE     = "tests/core_ctrl_vectors.txt";

  // One vector line, stimulus first and expected outputs after
  typedef struct packed {
    logic [7:0]     test;
    decode_fields_t fields;
    reg_addr_t      alu_rd;
    word_t          alu_res;
    logic           jump;
    logic           issued;
    logic           lsu_ready;
    logic [4:0]     mask;        // Stall, flush, redirect valid, redirect addr, PC
    logic           exp_stall;
    logic           exp_flush;
    redirect_t      exp_redirect;
    word_t          exp_pc;
  } vec_row_t;

  logic           clk;
  logic           rstn;
  decode_fields_t fields;
  reg_addr_t      alu_rd;
  word_t          alu_res;
  logic           jump;
  logic           issued;
  logic           lsu_ready;
  logic           stall;
  logic           flush;
  word_t          pc;
  redirect_t      redirect;

  // Expected side, handed to the checker
  logic           active;
  logic           done;
  logic [7:0]     test_num;
  logic [4:0]     mask;
  logic           exp_stall;
  logic           exp_flush;
  redirect_t      exp_redirect;
  word_t          exp_pc;
  int             pass_count;
  int             error_count;
  logic           report_done;

  vec_row_t rows[$];
  logic     load_ok;
  logic     started = 1'b0;
  int       timeout_ns;
  int       fails;

  core_ctrl_top #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_dut (
    .clk_i          (clk),
    .rstn_i         (rstn),
    .fields_i       (fields),
    .alu_rd_i       (alu_rd),
    .alu_res_i      (alu_res),
    .jump_i         (jump),
    .instr_issued_i (issued),
    .lsu_ready_i    (lsu_ready),
    .stall_o        (stall),
    .flush_o        (flush),
    .pc_o           (pc),
    .redirect_o     (redirect)
  );

  core_ctrl_checker i_checker (
    .clk_i          (clk),
    .active_i       (active),
    .done_i         (done),
    .test_i         (test_num),
    .mask_i         (mask),
    .exp_stall_i    (exp_stall),
    .exp_flush_i    (exp_flush),
    .exp_redirect_i (exp_redirect),
    .exp_pc_i       (exp_pc),
    .stall_i        (stall),
    .flush_i        (flush),
    .redirect_i     (redirect),
    .pc_i           (pc),
    .pass_count_o   (pass_count),
    .error_count_o  (error_count),
    .report_done_o  (report_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Vector file
  ////////////////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] col [18];
    vec_row_t    r;
    load_ok = 1'b0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open vector file %s", VEC_FILE);
    end else begin
      load_ok = 1'b1;
      while ($fgets(line, fd) > 0) begin
        // Column legend lines
        if (line[0] == "#") continue;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                    col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                    col[15], col[16], col[17]);
        if (n == 18) begin
          r.test             = col[0][7:0];
          r.fields.rs_a      = col[1][4:0];
          r.fields.rs_b      = col[2][4:0];
          r.fields.use_pc_a  = col[3][0];
          r.fields.use_imm_b = col[4][0];
          r.fields.lsu_cmd   = col[5][3:0];
          r.fields.lsu_valid = col[6][0];
          r.alu_rd           = col[7][4:0];
          r.alu_res          = col[8];
          r.jump             = col[9][0];
          r.issued           = col[10][0];
          r.lsu_ready        = col[11][0];
          r.mask             = col[12][4:0];
          r.exp_stall        = col[13][0];
          r.exp_flush        = col[14][0];
          r.exp_redirect     = {col[15][0], col[16]};
          r.exp_pc           = col[17];
          rows.push_back(r);
        end else if (n > 0) begin
          $display("Malformed vector line: %s", line);
          load_ok = 1'b0;
        end
      end
      $fclose(fd);
      // First row sits in reset, so the PC must show the boot address
      if (rows.size() == 0 || rows[0].exp_pc != BOOT_ADDR) begin
        $display("Vectors do not start at boot address %h", BOOT_ADDR);
        load_ok = 1'b0;
      end
    end
  endtask

  task automatic drive_row(input vec_row_t r);
    fields       = r.fields;
    alu_rd       = r.alu_rd;
    alu_res      = r.alu_res;
    jump         = r.jump;
    issued       = r.issued;
    lsu_ready    = r.lsu_ready;
    test_num     = r.test;
    mask         = r.mask;
    exp_stall    = r.exp_stall;
    exp_flush    = r.exp_flush;
    exp_redirect = r.exp_redirect;
    exp_pc       = r.exp_pc;
    active       = 1'b1;
  endtask

  ////////////////////////////////////////
  // Stimulus and summary
  ////////////////////////////////////////

  initial begin : stimulus
    rstn         = 1'b0;
    fields       = '0;
    alu_rd       = '0;
    alu_res      = '0;
    jump         = 1'b0;
    issued       = 1'b0;
    lsu_ready    = 1'b0;
    active       = 1'b0;
    done         = 1'b0;
    test_num     = '0;
    mask         = '0;
    exp_stall    = 1'b0;
    exp_flush    = 1'b0;
    exp_redirect = '0;
    exp_pc       = '0;
    load_vectors();
    timeout_ns = (rows.size() + RESET_CYCLES + 20) * CLK_PERIOD;
    if (!load_ok) begin
      $display("Test failed");
      $finish;
    end else begin
      started = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      foreach (rows[i]) begin
        @(negedge clk);
        // Reset drops together with the first row
        rstn = 1'b1;
        drive_row(rows[i]);
      end
      @(negedge clk);
      active = 1'b0;
      done   = 1'b1;
      wait (report_done);
      @(negedge clk);
      fails = error_count + i_dut.i_properties.assert_fails;
      $display("Summary: %0d checks passed, %0d errors, %0d assertion failures",
               pass_count, error_count, i_dut.i_properties.assert_fails);
      if (fails == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // Limit is the vector count plus reset and some slack
  initial begin : watchdog
    wait (started);
    #(timeout_ns);
    $display("Timeout: the run did not end within %0d ns", timeout_ns);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/core_ctrl_vectors.txt ====
# test rs_a rs_b pc_a imm_b lsu_cmd lsu_v alu_rd alu_res jump issued lsu_rdy, all hex
# then mask (b0 stall b1 flush b2 redir_v b3 redir_addr b4 pc) stall flush redir_v redir_addr pc
1 00 00 0 0 0 0 00 00000000 0 0 0 17 0 0 0 00000000 80000000
1 00 00 0 0 0 0 00 00000000 0 0 0 1f 0 0 1 80000000 80000000
1 00 00 0 0 0 0 00 00000000 0 0 0 17 0 0 0 00000000 80000000
1 00 00 0 0 0 0 00 00000000 0 0 0 17 0 0 0 00000000 80000000
2 00 00 0 0 0 0 00 00000000 0 1 0 17 0 0 0 00000000 80000000
2 00 00 0 0 0 0 00 00000000 0 1 0 17 0 0 0 00000000 80000004
2 00 00 0 0 0 0 00 00000000 0 0 0 17 0 0 0 00000000 80000008
2 00 00 0 0 0 0 00 00000000 0 0 0 17 0 0 0 00000000 80000008
2 00 00 0 0 0 0 00 00000000 0 1 0 17 0 0 0 00000000 80000008
3 05 00 0 0 0 0 05 00000000 0 0 0 17 1 0 0 00000000 8000000c
3 00 07 0 0 0 0 07 00000000 0 0 0 17 1 0 0 00000000 8000000c
3 00 00 0 0 0 0 00 00000000 0 0 0 17 0 0 0 00000000 8000000c
3 05 02 1 0 0 0 05 00000000 0 0 0 17 0 0 0 00000000 8000000c
3 01 07 0 1 0 0 07 00000000 0 0 0 17 0 0 0 00000000 8000000c
3 01 07 0 1 a 1 07 00000000 0 0 0 17 1 0 0 00000000 8000000c
4 00 00 0 1 a 1 03 00000000 0 0 0 17 0 0 0 00000000 8000000c
4 01 00 0 1 2 1 03 00000000 0 0 0 17 0 0 0 00000000 8000000c
4 00 00 0 0 0 0 00 00000000 0 0 0 17 1 0 0 00000000 8000000c
4 00 00 0 0 0 0 00 00000000 0 0 0 17 1 0 0 00000000 8000000c
4 00 00 0 0 0 0 00 00000000 0 0 0 17 1 0 0 00000000 8000000c
4 00 00 0 0 0 0 00 00000000 0 0 1 17 1 0 0 00000000 8000000c
4 00 00 0 0 0 0 00 00000000 0 0 0 17 0 0 0 00000000 8000000c
5 00 00 0 0 0 0 00 80000101 1 0 0 17 0 1 0 00000000 8000000c
5 00 00 0 0 0 0 00 80000101 0 0 0 1f 1 0 1 80000100 8000000c
5 00 00 0 0 0 0 00 80000101 0 0 0 17 1 0 0 00000000 80000100
5 00 00 0 0 0 0 00 80000101 0 0 0 17 0 0 0 00000000 80000100
6 00 00 0 0 2 1 00 80000203 1 0 0 17 0 1 0 00000000 80000100
6 00 00 0 0 0 0 00 80000203 0 0 0 1f 1 0 1 80000202 80000100
6 00 00 0 0 0 0 00 80000203 0 0 0 17 1 0 0 00000000 80000202
6 00 00 0 0 0 0 00 80000203 0 0 0 17 0 0 0 00000000 80000202

// ==== list.f ====
rtl/core_ctrl_pkg.sv
rtl/hazard_unit.sv
rtl/issue_fsm.sv
rtl/pc_counter.sv
rtl/core_ctrl_top.sv
tests/core_ctrl_properties.sv
tests/core_ctrl_checker.sv
tests/core_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the issue controller

VERILATOR ?= verilator
TOP       ?= core_ctrl_tb
RTL_TOP   ?= core_ctrl_top
FILELIST  ?= list.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
